//--- design/boot_image.svh
// RK11 disk bootstrap, one entry per word from the image base
`ifndef BOOT_IMAGE_SVH
`define BOOT_IMAGE_SVH

localparam iopage_word_t BOOT_IMAGE [ROM_WORDS] = '{
   16'o010000,
   // stack below the loaded block
   16'o012706, 16'o002000,
   // unit number into r0, then shift into the da field
   16'o012700, 16'o000000,
   16'o010003,
   16'o000303,
   16'o006303, 16'o006303, 16'o006303, 16'o006303, 16'o006303,
   // rkda, then ba and wc going down
   16'o012701, 16'o177412,
   16'o010311,
   16'o005041,
   16'o012741, 16'o177000,
   // read + go
   16'o012741, 16'o000005,
   16'o005002,
   16'o005003,
   16'o012704, 16'o002020,
   16'o005005,
   // wait for ready
   16'o105711,
   16'o100376,
   16'o105011,
   // jump to the loaded block at 0
   16'o005007
};

`endif

//--- design/boot_rom.sv
// boot ROM: window decode, image lookup, byte lane select
`timescale 1ns/10ps
`default_nettype none

module boot_rom (
   input  wire iopage_pkg::iopage_addr_t iopage_addr,
   input  wire logic                    iopage_rd,
   input  wire logic                    iopage_byte_op,
   output logic                         decode,
   output iopage_pkg::iopage_word_t      rdata
);
   import iopage_pkg::*;

   // image starts 1000 octal into the window
   localparam iopage_addr_t IMAGE_FIRST = ROM_FIRST + 13'o1000;

   iopage_addr_t word_addr;
   iopage_addr_t rel;
   logic [4:0]   index;
   logic         in_image;
   iopage_word_u fetch;

   always_comb
   begin
      word_addr = {iopage_addr[12:1], 1'b0};
      decode    = (word_addr >= ROM_FIRST) && (word_addr <= ROM_LAST);

      rel      = word_addr - IMAGE_FIRST;
      index    = rel[5:1];
      in_image = (word_addr >= IMAGE_FIRST) && (rel[12:1] < 12'(ROM_WORDS));

      // rest of the window reads as zero
      fetch.word = in_image ? BOOT_IMAGE[index] : '0;

      if (!(iopage_rd && decode))
         rdata = '0;
      else if (iopage_byte_op)
         rdata = {8'h00, fetch.lane[iopage_addr[0]]};
      else
         rdata = fetch.word;
   end

endmodule

`default_nettype wire

//--- design/bus_sequencer.sv
// I/O page bus cycle FSM: request latch, device strobes,
// read data select and done/nxm completion
`timescale 1ns/10ps
`default_nettype none

module bus_sequencer #(
   parameter int TIMEOUT_CYCLES = iopage_pkg::TIMEOUT_DEFAULT
) (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    req,
   input  wire logic                    wr,
   input  wire logic                    byte_op,
   input  wire iopage_pkg::iopage_addr_t addr,
   input  wire iopage_pkg::iopage_word_t wdata,
   input  wire logic                    rom_decode,
   input  wire logic                    con_decode,
   input  wire logic                    expired,
   input  wire iopage_pkg::iopage_word_t rom_rdata,
   input  wire iopage_pkg::iopage_word_t con_rdata,
   output iopage_pkg::iopage_addr_t      iopage_addr,
   output iopage_pkg::iopage_word_t      iopage_wdata,
   output logic                         iopage_rd,
   output logic                         iopage_wr,
   output logic                         iopage_byte_op,
   output logic                         run,
   output logic                         done,
   output logic                         nxm,
   output iopage_pkg::iopage_word_t      rdata
);
   import iopage_pkg::*;

   localparam logic ST_IDLE   = 1'b0;
   localparam logic ST_ACCESS = 1'b1;

   logic         state_q;
   iopage_addr_t addr_q;
   iopage_word_t wdata_q;
   logic         wr_q;
   logic         byte_q;
   logic         decoded;

   // a timeout of one cycle would end before any decode is seen
   if (TIMEOUT_CYCLES < 2) begin : g_bad_timeout
      $error("bus_sequencer: TIMEOUT_CYCLES must be 2 or more");
   end

   assign decoded = rom_decode | con_decode;

   assign iopage_addr    = addr_q;
   assign iopage_wdata   = wdata_q;
   assign iopage_byte_op = byte_q;
   assign iopage_rd      = (state_q == ST_ACCESS) && !wr_q;
   assign iopage_wr      = (state_q == ST_ACCESS) && wr_q;
   assign run            = (state_q == ST_ACCESS) && !decoded;

   // request copy
   always_ff @(posedge clk)
   begin
      if (state_q == ST_IDLE && req)
      begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wr_q    <= wr;
         byte_q  <= byte_op;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= ST_IDLE;
         done    <= 1'b0;
         nxm     <= 1'b0;
         rdata   <= '0;
      end
      else
      begin
         done <= 1'b0;
         if (state_q == ST_IDLE)
         begin
            if (req)
               state_q <= ST_ACCESS;
         end
         else if (decoded || expired)
         begin
            // devices return zero when not selected
            state_q <= ST_IDLE;
            done    <= 1'b1;
            nxm     <= !decoded;
            rdata   <= rom_decode ? rom_rdata : con_rdata;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/bus_timer.sv
// bus timeout counter for undecoded accesses
`timescale 1ns/10ps
`default_nettype none

module bus_timer #(
   parameter int TIMEOUT_CYCLES = iopage_pkg::TIMEOUT_DEFAULT
) (
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic run,
   output logic      expired
);
   localparam int CNT_W = $clog2(TIMEOUT_CYCLES);

   logic [CNT_W-1:0] count_q;

   // done follows on the next edge, so stop one short
   assign expired = (count_q == CNT_W'(TIMEOUT_CYCLES - 1));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         count_q <= '0;
      else if (!run)
         count_q <= '0;
      else if (!expired)
         count_q <= count_q + 1'b1;
   end

endmodule

`default_nettype wire

//--- design/console_regs.sv
// console switch register read and display register write
`timescale 1ns/10ps
`default_nettype none

module console_regs (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire iopage_pkg::iopage_addr_t iopage_addr,
   input  wire iopage_pkg::iopage_word_t iopage_wdata,
   input  wire logic                    iopage_rd,
   input  wire logic                    iopage_wr,
   input  wire logic                    iopage_byte_op,
   input  wire iopage_pkg::iopage_word_t switches,
   output logic                         decode,
   output iopage_pkg::iopage_word_t      rdata,
   output iopage_pkg::iopage_word_t      display
);
   import iopage_pkg::*;

   iopage_word_u sw_view;
   iopage_word_u disp_q;

   // odd address selects the high lane
   assign decode  = (iopage_addr[12:1] == CONSOLE_ADDR[12:1]);
   assign sw_view = switches;
   assign display = disp_q.word;

   always_comb
   begin
      if (!(iopage_rd && decode))
         rdata = '0;
      else if (iopage_byte_op)
         rdata = {8'h00, sw_view.lane[iopage_addr[0]]};
      else
         rdata = sw_view.word;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         disp_q <= '0;
      else if (iopage_wr && decode)
      begin
         // byte data always arrives on the low lane
         if (iopage_byte_op)
            disp_q.lane[iopage_addr[0]] <= iopage_wdata[7:0];
         else
            disp_q.word <= iopage_wdata;
      end
   end

endmodule

`default_nettype wire

//--- design/iopage_bus.sv
// I/O page slice top: sequencer, timeout counter, boot ROM
// and console register
`timescale 1ns/10ps
`default_nettype none

module iopage_bus #(
   parameter int TIMEOUT_CYCLES = iopage_pkg::TIMEOUT_DEFAULT
) (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    req,
   input  wire logic                    wr,
   input  wire logic                    byte_op,
   input  wire iopage_pkg::iopage_addr_t addr,
   input  wire iopage_pkg::iopage_word_t wdata,
   input  wire iopage_pkg::iopage_word_t switches,
   output iopage_pkg::iopage_word_t      rdata,
   output logic                         done,
   output logic                         nxm,
   output iopage_pkg::iopage_word_t      display
);
   import iopage_pkg::*;

   iopage_addr_t iopage_addr;
   iopage_word_t iopage_wdata;
   logic         iopage_rd;
   logic         iopage_wr;
   logic         iopage_byte_op;
   logic         run;
   logic         expired;
   logic         rom_decode;
   logic         con_decode;
   iopage_word_t rom_rdata;
   iopage_word_t con_rdata;

   bus_sequencer #(
      .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
   ) u_seq (
      .clk            (clk),
      .rst_n          (rst_n),
      .req            (req),
      .wr             (wr),
      .byte_op        (byte_op),
      .addr           (addr),
      .wdata          (wdata),
      .rom_decode     (rom_decode),
      .con_decode     (con_decode),
      .expired        (expired),
      .rom_rdata      (rom_rdata),
      .con_rdata      (con_rdata),
      .iopage_addr    (iopage_addr),
      .iopage_wdata   (iopage_wdata),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .run            (run),
      .done           (done),
      .nxm            (nxm),
      .rdata          (rdata)
   );

   bus_timer #(
      .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
   ) u_timer (
      .clk     (clk),
      .rst_n   (rst_n),
      .run     (run),
      .expired (expired)
   );

   boot_rom u_rom (
      .iopage_addr    (iopage_addr),
      .iopage_rd      (iopage_rd),
      .iopage_byte_op (iopage_byte_op),
      .decode         (rom_decode),
      .rdata          (rom_rdata)
   );

   console_regs u_console (
      .clk            (clk),
      .rst_n          (rst_n),
      .iopage_addr    (iopage_addr),
      .iopage_wdata   (iopage_wdata),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .switches       (switches),
      .decode         (con_decode),
      .rdata          (con_rdata),
      .display        (display)
   );

endmodule

`default_nettype wire

//--- design/iopage_pkg.sv
// I/O page widths, device addresses, byte/word union
// and the RK11 boot image constant
`default_nettype none

package iopage_pkg;

   // byte address within the 8 KB I/O page
   typedef logic [12:0] iopage_addr_t;

   typedef logic [15:0] iopage_word_t;

   // bus word, seen whole or as low/high byte lanes
   typedef union packed {
      iopage_word_t    word;
      logic [1:0][7:0] lane;
   } iopage_word_u;

   // boot ROM window, 173000 to 174776 on the full bus
   localparam iopage_addr_t ROM_FIRST = 13'o13000;
   localparam iopage_addr_t ROM_LAST  = 13'o14776;

   localparam int ROM_WORDS = 29;

   // switch register / display lights
   localparam iopage_addr_t CONSOLE_ADDR = 13'o17570;

   // cycles before an undecoded access ends with nxm
   localparam int TIMEOUT_DEFAULT = 8;

   `include "boot_image.svh"

endpackage

`default_nettype wire

//--- filelist.f
+incdir+design
design/iopage_pkg.sv
design/bus_timer.sv
design/bus_sequencer.sv
design/boot_rom.sv
design/console_regs.sv
design/iopage_bus.sv
tests/tb_iopage_bus.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the I/O page testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module tb_iopage_bus \
   -f filelist.f \
   -o sim_iopage_bus
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_iopage_bus
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0

//--- tests/tb_iopage_bus.sv
// testbench with clock, reset, stimulus, reference model
// and response checks for the I/O page slice
`timescale 1ns/10ps
`default_nettype none

module tb_iopage_bus;
   import iopage_pkg::*;

   localparam int TO_CYCLES   = 6;
   localparam int NUM_TXN     = 650;
   localparam int CYCLE_LIMIT = NUM_TXN * (TO_CYCLES + 3) + 50;

   typedef struct packed {
      logic         wr;
      logic         byte_op;
      iopage_addr_t addr;
      iopage_word_t wdata;
      iopage_word_t rdata;
      logic         nxm;
      int           due;
   } txn_t;

   logic         clk;
   logic         rst_n;
   logic         req;
   logic         wr;
   logic         byte_op;
   iopage_addr_t addr;
   iopage_word_t wdata;
   iopage_word_t switches;
   iopage_word_t rdata;
   logic         done;
   logic         nxm;
   iopage_word_t display;

   txn_t         pending[$];
   txn_t         head;
   iopage_word_t disp_model = '0;
   int           cycle_count = 0;

   iopage_bus #(
      .TIMEOUT_CYCLES(TO_CYCLES)
   ) DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .wr       (wr),
      .byte_op  (byte_op),
      .addr     (addr),
      .wdata    (wdata),
      .switches (switches),
      .rdata    (rdata),
      .done     (done),
      .nxm      (nxm),
      .display  (display)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run(string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
         $display("Errors found");
         $fatal(1, "compare failed");
      end
   endtask

   // {nxm, rdata} for a read of address a
   function automatic logic [16:0] expected_read(iopage_addr_t a, logic byte_sel,
                                                 iopage_word_t sw);
      iopage_addr_t wa;
      iopage_addr_t base;
      iopage_addr_t off;
      iopage_word_t w;
      wa   = {a[12:1], 1'b0};
      base = ROM_FIRST + 13'o1000;
      w    = '0;
      if (wa >= ROM_FIRST && wa <= ROM_LAST)
      begin
         if (wa >= base)
         begin
            off = (wa - base) >> 1;
            if (off < 13'(ROM_WORDS))
               w = BOOT_IMAGE[off[4:0]];
         end
      end
      else if (wa == CONSOLE_ADDR)
         w = sw;
      else
         return {1'b1, 16'h0000};
      if (byte_sel)
         w = a[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
      return {1'b0, w};
   endfunction

   function automatic iopage_addr_t random_undecoded();
      iopage_addr_t a;
      logic [16:0]  r;
      a = '0;
      r = '0;
      while (!r[16])
      begin
         a = 13'($urandom);
         r = expected_read(a, 1'b0, '0);
      end
      return a;
   endfunction

   // issue one request and wait for its done
   task automatic run_access(logic w, logic b, iopage_addr_t a, iopage_word_t d, int gap);
      txn_t        t;
      logic [16:0] r;
      r         = expected_read(a, b, switches);
      t.wr      = w;
      t.byte_op = b;
      t.addr    = a;
      t.wdata   = d;
      t.nxm     = r[16];
      t.rdata   = w ? 16'h0000 : r[15:0];
      t.due     = cycle_count + 1 + (r[16] ? TO_CYCLES : 1);
      pending.push_back(t);
      req     = 1'b1;
      wr      = w;
      byte_op = b;
      addr    = a;
      wdata   = d;
      @(negedge clk);
      req   = 1'b0;
      addr  = 13'($urandom);
      wdata = 16'($urandom);
      while (!done)
         @(negedge clk);
      repeat (gap) @(negedge clk);
   endtask

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT)
         abort_run("cycle limit reached before the tests finished");
   end

   always @(negedge clk)
   begin
      if (rst_n && done)
      begin
         if (pending.size() == 0)
            abort_run("done pulse without an outstanding request");
         else
         begin
            head = pending.pop_front();
            check_value("done cycle", 32'(cycle_count), 32'(head.due));
            check_value("rdata", 32'(rdata), 32'(head.rdata));
            check_value("nxm", 32'(nxm), 32'(head.nxm));
            if (head.wr && !head.nxm && head.addr[12:1] == CONSOLE_ADDR[12:1])
            begin
               if (!head.byte_op)
                  disp_model = head.wdata;
               else if (head.addr[0])
                  disp_model[15:8] = head.wdata[7:0];
               else
                  disp_model[7:0] = head.wdata[7:0];
            end
            check_value("display", 32'(display), 32'(disp_model));
         end
      end
      else if (rst_n && pending.size() != 0 && cycle_count > pending[0].due)
         abort_run("done never came for an outstanding request");
   end

   initial
   begin
      int a;
      void'($urandom(67));
      rst_n    = 1'b0;
      req      = 1'b0;
      wr       = 1'b0;
      byte_op  = 1'b0;
      addr     = '0;
      wdata    = '0;
      switches = '0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("done", 32'(done), 32'(0));
      check_value("nxm", 32'(nxm), 32'(0));
      check_value("rdata", 32'(rdata), 32'(0));
      check_value("display", 32'(display), 32'(0));

      // whole ROM window, word reads
      for (a = int'(ROM_FIRST); a <= int'(ROM_LAST); a += 2)
         run_access(1'b0, 1'b0, 13'(a), '0, 1);
      // image bytes, both lanes
      for (a = 0; a < 2 * ROM_WORDS; a++)
         run_access(1'b0, 1'b1, ROM_FIRST + 13'o1000 + 13'(a), '0, 1);
      repeat (8)
      begin
         switches = 16'($urandom);
         run_access(1'b0, 1'b0, CONSOLE_ADDR, '0, 1);
         run_access(1'b0, 1'b1, CONSOLE_ADDR, '0, 1);
         run_access(1'b0, 1'b1, CONSOLE_ADDR + 13'd1, '0, 1);
      end
      repeat (16)
      begin
         a = int'($urandom % 3);
         run_access(1'b1, a != 0, CONSOLE_ADDR + 13'(a == 2), 16'($urandom), 1);
      end
      repeat (8)
         run_access(1'b1, 1'($urandom), ROM_FIRST + 13'($urandom % 13'o2000),
                    16'($urandom), 1);
      repeat (16)
         run_access(1'($urandom), 1'($urandom), random_undecoded(), 16'($urandom), 1);

      // next request in the done cycle
      for (a = 0; a < 16; a++)
      begin
         case (a % 4)
            0: run_access(1'b0, 1'b0,
                          ROM_FIRST + 13'o1000 + 13'(2 * ($urandom % ROM_WORDS)), '0, 0);
            1: run_access(1'b1, 1'b1, CONSOLE_ADDR + 13'($urandom % 2), 16'($urandom), 0);
            2: run_access(1'b0, 1'b0, random_undecoded(), '0, 0);
            default:
            begin
               switches = 16'($urandom);
               run_access(1'b0, 1'b0, CONSOLE_ADDR, '0, 0);
            end
         endcase
      end

      @(negedge clk);
      if (pending.size() != 0)
         abort_run("requests left without done at the end of the test");
      else
      begin
         $display("No errors");
         $finish;
      end
   end

endmodule

`default_nettype wire
